/* src/cache_pkg.sv */
package cache_pkg;

    // Address layout
    localparam int addr_width = 32;
    localparam int s_offset   = 5;
    localparam int s_index    = 3;
    localparam int s_way      = 2;

    // Tag takes whatever is left above the index
    localparam int s_tag = addr_width - s_offset - s_index;

    // One line is 2**s_offset bytes
    localparam int s_line = 8 * (2**s_offset);

    localparam int num_ways = 2**s_way;
    localparam int num_sets = 2**s_index;

    // Per-way metadata kept in the tag store
    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [s_tag-1:0] tag;
    } tag_entry_t;

endpackage

/* src/set_array.sv */
`timescale 1ns/1ps

module set_array #(
    parameter int  s_index   = cache_pkg::s_index,
    parameter type payload_t = cache_pkg::tag_entry_t
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               read,
    input  logic [s_index-1:0] rindex,
    input  logic               load,
    input  logic [s_index-1:0] windex,
    input  payload_t           datain,
    output payload_t           dataout
);

    localparam int n_sets = 2**s_index;

    payload_t store [n_sets];

    // Registered read, output holds while read is low
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < n_sets; s++) begin
                store[s] <= '0;
            end
            dataout <= '0;
        end else begin
            if (load) begin
                store[windex] <= datain;
            end
            // Same-set write in this cycle is not seen here
            if (read) begin
                dataout <= store[rindex];
            end
        end
    end

endmodule

/* src/way_lookup.sv */
`timescale 1ns/1ps

module way_lookup #(
    parameter int s_way = cache_pkg::s_way
) (
    input  cache_pkg::tag_entry_t        entries [2**s_way],
    input  logic [cache_pkg::s_line-1:0] lines   [2**s_way],
    input  logic [cache_pkg::s_tag-1:0]  tag_act,
    input  logic [2**s_way-1:0]          fw_way,
    input  cache_pkg::tag_entry_t        fw_entry,
    input  logic [cache_pkg::s_line-1:0] fw_line,
    input  logic [2**s_way-1:0]          victim,
    output logic                         hit,
    output logic [2**s_way-1:0]          way,
    output logic [cache_pkg::s_line-1:0] sel_line,
    output logic [cache_pkg::s_tag-1:0]  sel_tag,
    output logic                         sel_dirty
);

    import cache_pkg::*;

    localparam int n_ways = 2**s_way;

    tag_entry_t        eff_entry [n_ways];
    logic [s_line-1:0] eff_line  [n_ways];
    logic [n_ways-1:0] hits;

    // A forwarded way replaces the stale array output
    always_comb begin
        for (int w = 0; w < n_ways; w++) begin
            eff_entry[w] = fw_way[w] ? fw_entry : entries[w];
            eff_line[w]  = fw_way[w] ? fw_line : lines[w];
            hits[w]      = eff_entry[w].valid && (eff_entry[w].tag == tag_act);
        end
    end

    assign hit = |hits;

    // Hit way, or the LRU victim on a miss
    assign way = hit ? hits : victim;

    always_comb begin
        sel_line  = '0;
        sel_tag   = '0;
        sel_dirty = 1'b0;
        for (int w = 0; w < n_ways; w++) begin
            if (way[w]) begin
                sel_line  = eff_line[w];
                sel_tag   = eff_entry[w].tag;
                sel_dirty = eff_entry[w].dirty;
            end
        end
    end

endmodule

/* src/lru_tracker.sv */
`timescale 1ns/1ps

module lru_tracker #(
    parameter int s_index = cache_pkg::s_index,
    parameter int s_way   = cache_pkg::s_way
) (
    input  logic               clk,
    input  logic               reset,
    input  logic [s_index-1:0] index,
    input  logic               update,
    input  logic [2**s_way-1:0] used_way,
    output logic [2**s_way-1:0] victim
);

    localparam int n_sets = 2**s_index;
    localparam int n_ways = 2**s_way;

    // Heap-ordered tree, node n at bit n-1, a 0 bit points to the lower half
    logic [n_ways-2:0] tree [n_sets];
    logic [n_ways-2:0] cur_bits;
    logic [n_ways-2:0] next_bits;
    logic [s_way-1:0]  used_idx;

    assign cur_bits = tree[index];

    // Walk down the tree following the bits
    always_comb begin
        int node;
        node = 1;
        for (int l = 0; l < s_way; l++) begin
            node = 2 * node + int'(cur_bits[node-1]);
        end
        victim = '0;
        victim[node-n_ways] = 1'b1;
    end

    always_comb begin
        used_idx = '0;
        for (int w = 0; w < n_ways; w++) begin
            if (used_way[w]) begin
                used_idx = s_way'(w);
            end
        end
    end

    // Point every node on the used path to the other side
    always_comb begin
        int node;
        next_bits = cur_bits;
        node      = 1;
        for (int l = s_way - 1; l >= 0; l--) begin
            next_bits[node-1] = ~used_idx[l];
            node = 2 * node + int'(used_idx[l]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < n_sets; s++) begin
                tree[s] <= '0;
            end
        end else if (update) begin
            tree[index] <= next_bits;
        end
    end

endmodule

/* src/cache_core.sv */
`timescale 1ns/1ps

module cache_core #(
    parameter int s_index = cache_pkg::s_index,
    parameter int s_way   = cache_pkg::s_way
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             stall,
    input  logic                             upstream_read,
    input  logic                             upstream_write,
    input  logic [cache_pkg::addr_width-1:0] upstream_address,
    input  logic [cache_pkg::s_line-1:0]     upstream_wdata,
    output logic                             upstream_resp,
    output logic [cache_pkg::s_line-1:0]     upstream_rdata,
    output logic                             downstream_read,
    output logic                             downstream_write,
    output logic [cache_pkg::addr_width-1:0] downstream_address,
    output logic [cache_pkg::s_line-1:0]     downstream_wdata,
    input  logic                             downstream_resp,
    input  logic [cache_pkg::s_line-1:0]     downstream_rdata,
    output logic [s_index-1:0]               read_index,
    output logic [s_index-1:0]               write_index,
    output logic                             pipe,
    output logic [2**s_way-1:0]              way_load,
    output cache_pkg::tag_entry_t            new_entry,
    output logic [cache_pkg::s_line-1:0]     new_line,
    output logic [cache_pkg::s_tag-1:0]      tag_act,
    output logic [2**s_way-1:0]              fw_way,
    output cache_pkg::tag_entry_t            fw_entry,
    output logic [cache_pkg::s_line-1:0]     fw_line,
    input  logic                             hit,
    input  logic [2**s_way-1:0]              way,
    input  logic [cache_pkg::s_line-1:0]     sel_line,
    input  logic [cache_pkg::s_tag-1:0]      sel_tag,
    input  logic                             sel_dirty,
    output logic                             lru_update,
    output logic [2**s_way-1:0]              lru_used
);

    import cache_pkg::*;

    localparam int n_ways = 2**s_way;

    // Phases of the request held in the action stage
    typedef enum logic [1:0] {
        ph_look,
        ph_wb,
        ph_fill,
        ph_done
    } phase_t;

    // High while a request occupies the action stage
    logic                  cache_started;
    logic                  write_act;
    logic [addr_width-1:0] addr_act;
    logic [s_line-1:0]     wdata_act;
    logic [s_index-1:0]    index_act;
    phase_t                phase;
    phase_t                phase_next;
    logic                  fill_now;
    logic                  complete;
    logic                  load_cache;
    logic [n_ways-1:0]     fw_next;
    logic [s_tag-1:0]      wb_tag;
    logic [s_index-1:0]    wb_index;
    logic [s_line-1:0]     wb_line;
    logic [s_line-1:0]     held_line;

    assign tag_act     = addr_act[addr_width-1 -: s_tag];
    assign index_act   = addr_act[s_offset +: s_index];
    assign read_index  = upstream_address[s_offset +: s_index];
    assign write_index = index_act;

    // Clean miss goes straight to the fill read
    assign fill_now = (phase == ph_look && !hit && !sel_dirty) || phase == ph_fill;

    // ph_done keeps a finished access alive under stall
    assign complete = cache_started && ((phase == ph_look && hit) ||
                                        (fill_now && downstream_resp) ||
                                        phase == ph_done);

    assign pipe       = (complete && !stall) || !cache_started;
    assign lru_update = complete && !stall;
    assign lru_used   = way;
    assign load_cache = lru_update && (write_act || !hit);
    assign way_load   = {n_ways{load_cache}} & way;

    // Only the first completion cycle is reported upstream
    assign upstream_resp  = complete && phase != ph_done;
    assign upstream_rdata = hit ? sel_line : downstream_rdata;

    // Writes go in dirty, read fills go in clean
    assign new_entry.valid = 1'b1;
    assign new_entry.dirty = write_act;
    assign new_entry.tag   = tag_act;
    assign new_line = write_act ? wdata_act : (phase == ph_done ? held_line : downstream_rdata);

    assign downstream_write   = cache_started && phase == ph_wb;
    assign downstream_read    = cache_started && fill_now;
    assign downstream_wdata   = wb_line;
    assign downstream_address = (phase == ph_wb) ? {wb_tag, wb_index, {s_offset{1'b0}}}
                                                 : {addr_act[addr_width-1:s_offset],
                                                    {s_offset{1'b0}}};

    // The set being read now is the one written now
    assign fw_next = (read_index == index_act && load_cache) ? way : '0;

    always_comb begin
        phase_next = phase;
        if (pipe) begin
            phase_next = ph_look;
        end else if (complete) begin
            phase_next = ph_done;
        end else if (phase == ph_look) begin
            phase_next = sel_dirty ? ph_wb : ph_fill;
        end else if (phase == ph_wb && downstream_resp) begin
            phase_next = ph_fill;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cache_started <= 1'b0;
            write_act     <= 1'b0;
            addr_act      <= '0;
            fw_way        <= '0;
            phase         <= ph_look;
        end else begin
            if (pipe) begin
                // While resp is high the requester still shows the old access
                cache_started <= (upstream_read || upstream_write) && !upstream_resp;
                write_act     <= upstream_write;
                addr_act      <= upstream_address;
                fw_way        <= fw_next;
            end
            phase <= phase_next;
        end
    end

    always_ff @(posedge clk) begin
        if (pipe) begin
            wdata_act <= upstream_wdata;
            fw_entry  <= new_entry;
            fw_line   <= new_line;
        end
        // Victim snapshot taken during lookup
        if (phase == ph_look) begin
            wb_tag   <= sel_tag;
            wb_index <= index_act;
            wb_line  <= sel_line;
        end
        if (fill_now && downstream_resp) begin
            held_line <= downstream_rdata;
        end
    end

endmodule

/* src/cache_top.sv */
`timescale 1ns/1ps

module cache_top #(
    parameter int s_index = cache_pkg::s_index,
    parameter int s_way   = cache_pkg::s_way
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             stall,
    input  logic                             upstream_read,
    input  logic                             upstream_write,
    input  logic [cache_pkg::addr_width-1:0] upstream_address,
    input  logic [cache_pkg::s_line-1:0]     upstream_wdata,
    output logic                             upstream_resp,
    output logic [cache_pkg::s_line-1:0]     upstream_rdata,
    output logic                             downstream_read,
    output logic                             downstream_write,
    output logic [cache_pkg::addr_width-1:0] downstream_address,
    output logic [cache_pkg::s_line-1:0]     downstream_wdata,
    input  logic                             downstream_resp,
    input  logic [cache_pkg::s_line-1:0]     downstream_rdata
);

    import cache_pkg::*;

    localparam int n_ways = 2**s_way;

    logic [s_index-1:0] read_index;
    logic [s_index-1:0] write_index;
    logic               pipe;
    logic [n_ways-1:0]  way_load;
    tag_entry_t         new_entry;
    logic [s_line-1:0]  new_line;
    tag_entry_t         entries [n_ways];
    logic [s_line-1:0]  lines   [n_ways];
    logic [s_tag-1:0]   tag_act;
    logic [n_ways-1:0]  fw_way;
    tag_entry_t         fw_entry;
    logic [s_line-1:0]  fw_line;
    logic [n_ways-1:0]  victim;
    logic               hit;
    logic [n_ways-1:0]  way;
    logic [s_line-1:0]  sel_line;
    logic [s_tag-1:0]   sel_tag;
    logic               sel_dirty;
    logic               lru_update;
    logic [n_ways-1:0]  lru_used;

    // Tag and data stores per way, sharing indices and enables
    for (genvar w = 0; w < n_ways; w++) begin : g_way
        set_array #(
            .s_index   (s_index),
            .payload_t (tag_entry_t)
        ) tag_store (
            .clk     (clk),
            .reset   (reset),
            .read    (pipe),
            .rindex  (read_index),
            .load    (way_load[w]),
            .windex  (write_index),
            .datain  (new_entry),
            .dataout (entries[w])
        );

        set_array #(
            .s_index   (s_index),
            .payload_t (logic [s_line-1:0])
        ) data_store (
            .clk     (clk),
            .reset   (reset),
            .read    (pipe),
            .rindex  (read_index),
            .load    (way_load[w]),
            .windex  (write_index),
            .datain  (new_line),
            .dataout (lines[w])
        );
    end

    way_lookup #(
        .s_way (s_way)
    ) lookup (
        .entries   (entries),
        .lines     (lines),
        .tag_act   (tag_act),
        .fw_way    (fw_way),
        .fw_entry  (fw_entry),
        .fw_line   (fw_line),
        .victim    (victim),
        .hit       (hit),
        .way       (way),
        .sel_line  (sel_line),
        .sel_tag   (sel_tag),
        .sel_dirty (sel_dirty)
    );

    // LRU state is looked up at the action-stage set
    lru_tracker #(
        .s_index (s_index),
        .s_way   (s_way)
    ) lru (
        .clk      (clk),
        .reset    (reset),
        .index    (write_index),
        .update   (lru_update),
        .used_way (lru_used),
        .victim   (victim)
    );

    cache_core #(
        .s_index (s_index),
        .s_way   (s_way)
    ) core (
        .clk                (clk),
        .reset              (reset),
        .stall              (stall),
        .upstream_read      (upstream_read),
        .upstream_write     (upstream_write),
        .upstream_address   (upstream_address),
        .upstream_wdata     (upstream_wdata),
        .upstream_resp      (upstream_resp),
        .upstream_rdata     (upstream_rdata),
        .downstream_read    (downstream_read),
        .downstream_write   (downstream_write),
        .downstream_address (downstream_address),
        .downstream_wdata   (downstream_wdata),
        .downstream_resp    (downstream_resp),
        .downstream_rdata   (downstream_rdata),
        .read_index         (read_index),
        .write_index        (write_index),
        .pipe               (pipe),
        .way_load           (way_load),
        .new_entry          (new_entry),
        .new_line           (new_line),
        .tag_act            (tag_act),
        .fw_way             (fw_way),
        .fw_entry           (fw_entry),
        .fw_line            (fw_line),
        .hit                (hit),
        .way                (way),
        .sel_line           (sel_line),
        .sel_tag            (sel_tag),
        .sel_dirty          (sel_dirty),
        .lru_update         (lru_update),
        .lru_used           (lru_used)
    );

endmodule

/* sim/cache_sva.sv */
`timescale 1ns/1ps

module cache_sva (
    input logic                             clk,
    input logic                             reset,
    input logic                             upstream_read,
    input logic                             upstream_write,
    input logic                             upstream_resp,
    input logic                             downstream_read,
    input logic                             downstream_write,
    input logic [cache_pkg::addr_width-1:0] downstream_address,
    input logic                             downstream_resp
);

    // One downstream transfer at a time
    one_transfer: assert property (@(posedge clk) disable iff (reset)
        !(downstream_read && downstream_write))
        else $error("downstream_read and downstream_write are high together");

    // Address held until the memory answers
    address_held: assert property (@(posedge clk) disable iff (reset)
        (downstream_read || downstream_write) && !downstream_resp
        |=> $stable(downstream_address))
        else $error("downstream_address changed before downstream_resp");

    resp_has_request: assert property (@(posedge clk) disable iff (reset)
        upstream_resp |-> (upstream_read || upstream_write))
        else $error("upstream_resp without a pending request");

endmodule

bind cache_top cache_sva sva_i (
    .clk                (clk),
    .reset              (reset),
    .upstream_read      (upstream_read),
    .upstream_write     (upstream_write),
    .upstream_resp      (upstream_resp),
    .downstream_read    (downstream_read),
    .downstream_write   (downstream_write),
    .downstream_address (downstream_address),
    .downstream_resp    (downstream_resp)
);

/* sim/tb_cache.sv */
`timescale 1ns/1ps

module tb_cache;

    import cache_pkg::*;

    localparam int max_ops  = 64;
    localparam int wait_max = 500;
    localparam int words    = s_line / 32;

    logic                  clk;
    logic                  reset;
    logic                  stall;
    logic                  upstream_read;
    logic                  upstream_write;
    logic [addr_width-1:0] upstream_address;
    logic [s_line-1:0]     upstream_wdata;
    logic                  upstream_resp;
    logic [s_line-1:0]     upstream_rdata;
    logic                  downstream_read;
    logic                  downstream_write;
    logic [addr_width-1:0] downstream_address;
    logic [s_line-1:0]     downstream_wdata;
    logic                  downstream_resp;
    logic [s_line-1:0]     downstream_rdata;

    // Downstream memory model
    logic [s_line-1:0]     mem_lines [logic [addr_width-1:0]];
    logic                  mem_busy;
    int unsigned           mem_delay;
    int                    rd_count;
    int                    wr_count;
    logic                  order_bad;
    logic [addr_width-1:0] wb_addr;
    logic [31:0]           wb_word;

    // Reference tags and pseudo-LRU bits
    logic                  ref_valid [num_sets][num_ways];
    logic                  ref_dirty [num_sets][num_ways];
    logic [s_tag-1:0]      ref_tag   [num_sets][num_ways];
    logic [31:0]           ref_word  [num_sets][num_ways];
    logic [num_ways-2:0]   ref_tree  [num_sets];

    logic [31:0]           patterns [4*max_ops];
    int                    errors;
    int                    checks;
    int                    op_index;
    logic                  timed_out;

    cache_top dut_i (
        .clk                (clk),
        .reset              (reset),
        .stall              (stall),
        .upstream_read      (upstream_read),
        .upstream_write     (upstream_write),
        .upstream_address   (upstream_address),
        .upstream_wdata     (upstream_wdata),
        .upstream_resp      (upstream_resp),
        .upstream_rdata     (upstream_rdata),
        .downstream_read    (downstream_read),
        .downstream_write   (downstream_write),
        .downstream_address (downstream_address),
        .downstream_wdata   (downstream_wdata),
        .downstream_resp    (downstream_resp),
        .downstream_rdata   (downstream_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Untouched memory returns the inverted line address in every word
    function automatic logic [31:0] fill_word(logic [addr_width-1:0] addr);
        return ~addr;
    endfunction

    // Follow the tree bits from the root down to a way
    function automatic int tree_victim(logic [num_ways-2:0] bits);
        int node;
        node = 1;
        for (int l = 0; l < s_way; l++) begin
            node = 2 * node + (bits[node-1] ? 1 : 0);
        end
        return node - num_ways;
    endfunction

    // Every node on the path to the used way points to the other half
    function automatic logic [num_ways-2:0] tree_touch(logic [num_ways-2:0] bits, int way);
        int                  node;
        int                  side;
        logic [num_ways-2:0] result;
        result = bits;
        node   = 1;
        for (int l = s_way - 1; l >= 0; l--) begin
            side           = (way >> l) & 1;
            result[node-1] = (side == 0);
            node           = 2 * node + side;
        end
        return result;
    endfunction

    task automatic compare_value(input string name, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("mismatch %s %s: expected %h, actual %h", name, what, expected, actual);
            errors++;
        end
    endtask

    // Answers one downstream request after a random number of cycles
    task automatic serve_memory();
        logic [addr_width-1:0] line_addr;
        line_addr        = downstream_address;
        downstream_resp  = 1'b0;
        downstream_rdata = '1;
        if (!(downstream_read || downstream_write)) begin
            mem_busy = 1'b0;
        end else begin
            if (!mem_busy) begin
                mem_busy  = 1'b1;
                mem_delay = $urandom % 4;
            end
            if (mem_delay != 0) begin
                mem_delay--;
            end else begin
                mem_busy        = 1'b0;
                downstream_resp = 1'b1;
                if (downstream_write) begin
                    mem_lines[line_addr] = downstream_wdata;
                    wb_addr = line_addr;
                    wb_word = downstream_wdata[31:0];
                    wr_count++;
                    if (rd_count != 0) begin
                        order_bad = 1'b1;
                    end
                end else begin
                    downstream_rdata = mem_lines.exists(line_addr) ? mem_lines[line_addr]
                                                                   : {words{fill_word(line_addr)}};
                    rd_count++;
                end
            end
        end
    endtask

    task automatic next_falling(input logic hold_stall);
        @(negedge clk);
        stall = hold_stall || (($urandom % 5) == 0);
        serve_memory();
    endtask

    task automatic run_op(input int num, input logic [31:0] op, input logic [31:0] addr,
                          input logic [31:0] wword, input logic [31:0] rword);
        string                 name;
        logic [s_index-1:0]    set;
        logic [s_tag-1:0]      tag;
        int                    hit_way;
        int                    way;
        logic                  exp_wb;
        logic [addr_width-1:0] exp_wb_addr;
        logic [31:0]           exp_wb_word;
        logic                  got;
        logic [31:0]           got_word;
        int                    cycles;

        name    = $sformatf("op%0d %s %h", num, (op == 2) ? "write" : "read", addr);
        set     = addr[s_offset +: s_index];
        tag     = addr[addr_width-1 -: s_tag];
        hit_way = -1;
        for (int w = 0; w < num_ways; w++) begin
            if (ref_valid[set][w] && ref_tag[set][w] == tag) begin
                hit_way = w;
            end
        end
        way         = (hit_way >= 0) ? hit_way : tree_victim(ref_tree[set]);
        exp_wb      = (hit_way < 0) && ref_valid[set][way] && ref_dirty[set][way];
        exp_wb_addr = {ref_tag[set][way], set, {s_offset{1'b0}}};
        exp_wb_word = ref_word[set][way];

        rd_count  = 0;
        wr_count  = 0;
        order_bad = 1'b0;
        next_falling(1'b0);
        upstream_read    = (op == 1);
        upstream_write   = (op == 2);
        upstream_address = addr;
        upstream_wdata   = {words{wword}};
        #10;
        checks++;
        assert (!upstream_resp) else begin
            $display("%s: upstream_resp came before the request could be taken", name);
            errors++;
        end

        got    = 1'b0;
        cycles = 0;
        while (!got && cycles < wait_max) begin
            // A write ends under stall so the next access of its set takes the forwarded line
            next_falling(op == 2);
            #10;
            if (upstream_resp) begin
                got      = 1'b1;
                got_word = upstream_rdata[31:0];
            end
            cycles++;
        end

        if (!got) begin
            $display("timeout: %s got no upstream_resp within %0d cycles", name, wait_max);
            errors++;
            timed_out = 1'b1;
        end else begin
            if (op == 1) begin
                compare_value(name, "read word", rword, got_word);
            end
            compare_value(name, "fill reads", (hit_way < 0) ? 1 : 0, rd_count);
            compare_value(name, "write-backs", exp_wb ? 1 : 0, wr_count);
            if (exp_wb) begin
                compare_value(name, "write-back address", exp_wb_addr, wb_addr);
                compare_value(name, "write-back word", exp_wb_word, wb_word);
            end
            checks++;
            assert (!order_bad) else begin
                $display("%s: the write-back came after the fill read", name);
                errors++;
            end
            ref_valid[set][way] = 1'b1;
            ref_tag[set][way]   = tag;
            if (op == 2) begin
                ref_dirty[set][way] = 1'b1;
                ref_word[set][way]  = wword;
            end else if (hit_way < 0) begin
                ref_dirty[set][way] = 1'b0;
                ref_word[set][way]  = rword;
            end
            ref_tree[set] = tree_touch(ref_tree[set], way);
        end
    endtask

    initial begin
        void'($urandom(13));
        reset            = 1'b1;
        stall            = 1'b0;
        upstream_read    = 1'b0;
        upstream_write   = 1'b0;
        upstream_address = '0;
        upstream_wdata   = '0;
        downstream_resp  = 1'b0;
        downstream_rdata = '0;
        mem_busy         = 1'b0;
        mem_delay        = 0;
        rd_count         = 0;
        wr_count         = 0;
        order_bad        = 1'b0;
        wb_addr          = '0;
        wb_word          = '0;
        errors           = 0;
        checks           = 0;
        timed_out        = 1'b0;
        for (int s = 0; s < num_sets; s++) begin
            ref_tree[s] = '0;
            for (int w = 0; w < num_ways; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
                ref_tag[s][w]   = '0;
                ref_word[s][w]  = '0;
            end
        end
        for (int i = 0; i < 4 * max_ops; i++) begin
            patterns[i] = '0;
        end
        $readmemh("sim/cache_patterns.txt", patterns);

        repeat (3) @(negedge clk);
        reset = 1'b0;

        op_index = 0;
        while (op_index < max_ops && !timed_out && patterns[4*op_index] != 0) begin
            run_op(op_index, patterns[4*op_index], patterns[4*op_index+1],
                   patterns[4*op_index+2], patterns[4*op_index+3]);
            op_index++;
        end
        checks++;
        assert (op_index > 0) else begin
            $display("no operations were read from the pattern file");
            errors++;
        end

        // A finished access must not pulse upstream_resp again
        for (int i = 0; i < 8 && !timed_out; i++) begin
            next_falling(1'b0);
            upstream_read  = 1'b0;
            upstream_write = 1'b0;
            #10;
            checks++;
            assert (!upstream_resp) else begin
                $display("upstream_resp pulsed with no request pending");
                errors++;
            end
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* sim/cache_patterns.txt */
// Columns: op (1 read, 2 write), line address, write word, expected read word
// Writes carry zero in the last column
00000001 00001000 00000000 ffffefff
00000001 00001000 00000000 ffffefff
00000002 00002020 a5a50001 00000000
00000001 00002020 00000000 a5a50001
00000001 00010040 00000000 fffeffbf
00000001 00020040 00000000 fffdffbf
00000001 00030040 00000000 fffcffbf
00000001 00040040 00000000 fffbffbf
00000001 00050040 00000000 fffaffbf
00000001 00010040 00000000 fffeffbf
00000002 00001060 d1d10001 00000000
00000001 00002060 00000000 ffffdf9f
00000001 00003060 00000000 ffffcf9f
00000001 00004060 00000000 ffffbf9f
00000001 00005060 00000000 ffffaf9f
00000001 00001060 00000000 d1d10001
00000002 00001000 12340007 00000000
00000001 00001000 00000000 12340007
00000002 00002000 beef0002 00000000
00000001 00002000 00000000 beef0002
00000001 00001000 00000000 12340007
00000001 00002020 00000000 a5a50001
00000002 00002020 0f0f0003 00000000
00000001 00002020 00000000 0f0f0003
00000001 000010e0 00000000 ffffef1f
00000001 000010e0 00000000 ffffef1f

/* list.f */
src/cache_pkg.sv
src/set_array.sv
src/way_lookup.sv
src/lru_tracker.sv
src/cache_core.sv
src/cache_top.sv
sim/cache_sva.sv
sim/tb_cache.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_cache -Mdir obj_dir -f list.f

status=0
./obj_dir/Vtb_cache > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "=== FAIL ===" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
